/* rtl/ooo_cfg_pkg.sv */
package ooo_cfg_pkg;

    ////////////////////////////////////////
    // datapath and buffer sizes
    ////////////////////////////////////////
    localparam int xlen        = 32;  // data width
    localparam int rob_size    = 8;   // reorder buffer entries
    localparam int rob_idx_len = 3;   // width of a rob tag
    localparam int rob_cnt_len = 4;   // one bit wider than the tag
    localparam int num_regs    = 32;  // architectural registers
    localparam int reg_idx_len = 5;   // register index width
    localparam int imm_len     = 12;  // immediate width in the word

    ////////////////////////////////////////
    // derived constants
    ////////////////////////////////////////
    localparam logic [reg_idx_len-1:0] zero_reg     = '0;  // never written
    localparam logic [xlen-1:0]        pc_step      = xlen'(4);  // link offset
    localparam logic [rob_idx_len-1:0] rob_last     = rob_idx_len'(rob_size - 1);
    localparam logic [rob_cnt_len-1:0] rob_full_cnt = rob_cnt_len'(rob_size);

    // branch compare kinds
    localparam logic cond_eq = 1'b0;
    localparam logic cond_lt = 1'b1;  // signed less than

endpackage

/* rtl/ooo_types_pkg.sv */
package ooo_types_pkg;

    typedef enum logic [1:0] {
        alu_add = 2'd0,
        alu_sub = 2'd1,
        alu_and = 2'd2,
        alu_xor = 2'd3
    } alu_op_e;

    ////////////////////////////////////////
    // instruction word, two readings
    ////////////////////////////////////////
    typedef struct packed {
        logic                                is_branch;  // 0 in this form
        alu_op_e                             op;
        logic [ooo_cfg_pkg::reg_idx_len-1:0] dest;
        logic [ooo_cfg_pkg::imm_len-1:0]     imm_a;
        logic [ooo_cfg_pkg::imm_len-1:0]     imm_b;
    } alu_form_t;

    typedef struct packed {
        logic                                is_branch;  // 1 in this form
        logic                                pred_taken;
        logic                                cond;       // eq or signed lt
        logic [ooo_cfg_pkg::reg_idx_len-1:0] dest;       // zero_reg means no link
        logic [ooo_cfg_pkg::imm_len-1:0]     cmp_a;
        logic [ooo_cfg_pkg::imm_len-1:0]     cmp_b;      // also the taken offset
    } br_form_t;

    // is_branch is the top bit of both forms
    typedef union packed {
        alu_form_t alu;
        br_form_t  br;
    } instr_word_u;

    ////////////////////////////////////////
    // pipeline transfer records
    ////////////////////////////////////////
    typedef struct packed {
        logic                                valid;
        logic [ooo_cfg_pkg::rob_idx_len-1:0] tag;
        logic [ooo_cfg_pkg::xlen-1:0]        pc;
        logic                                is_branch;
        alu_op_e                             alu_op;
        logic                                cond;
        logic                                pred_taken;
        logic [ooo_cfg_pkg::reg_idx_len-1:0] dest;
        logic [ooo_cfg_pkg::xlen-1:0]        op_a;
        logic [ooo_cfg_pkg::xlen-1:0]        op_b;
    } exec_op_t;

    typedef struct packed {
        logic                                valid;
        logic [ooo_cfg_pkg::rob_idx_len-1:0] tag;
        logic [ooo_cfg_pkg::xlen-1:0]        value;   // result, link or target
        logic [ooo_cfg_pkg::xlen-1:0]        target;  // branch outcome pc
        logic                                mis_pred;
    } complete_t;

    typedef struct packed {
        logic                                valid;
        logic [ooo_cfg_pkg::xlen-1:0]        pc;
        logic [ooo_cfg_pkg::reg_idx_len-1:0] dest;
        logic [ooo_cfg_pkg::xlen-1:0]        value;
        logic                                squash;
    } retire_t;

endpackage

/* rtl/dispatch_stage.sv */
`timescale 1ns/1ps

module dispatch_stage (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                instr_valid,
    input  ooo_types_pkg::instr_word_u          instr,
    input  logic [ooo_cfg_pkg::xlen-1:0]        pc,
    input  logic                                instr_ready,
    input  logic [ooo_cfg_pkg::rob_idx_len-1:0] alloc_tag,
    input  logic                                squash,
    output logic                                alloc,
    output ooo_types_pkg::exec_op_t             op
);

    ooo_types_pkg::exec_op_t dec;

    function automatic logic [ooo_cfg_pkg::xlen-1:0] sext(
        input logic [ooo_cfg_pkg::imm_len-1:0] imm
    );
        return {{(ooo_cfg_pkg::xlen - ooo_cfg_pkg::imm_len){imm[ooo_cfg_pkg::imm_len-1]}}, imm};
    endfunction

    assign alloc = instr_valid && instr_ready && !squash;  // nothing enters during squash

    always_comb begin
        dec           = '0;
        dec.valid     = 1'b1;
        dec.tag       = alloc_tag;  // rob tail at accept
        dec.pc        = pc;
        dec.is_branch = instr.alu.is_branch;
        if (instr.alu.is_branch) begin
            dec.cond       = instr.br.cond;
            dec.pred_taken = instr.br.pred_taken;
            dec.dest       = instr.br.dest;  // zero_reg when no link
            dec.op_a       = sext(instr.br.cmp_a);
            dec.op_b       = sext(instr.br.cmp_b);
        end else begin
            dec.alu_op = instr.alu.op;
            dec.dest   = instr.alu.dest;
            dec.op_a   = sext(instr.alu.imm_a);
            dec.op_b   = sext(instr.alu.imm_b);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            op.valid <= 1'b0;
        end else if (alloc) begin
            op <= dec;
        end else begin
            op.valid <= 1'b0;  // bubble, also covers squash
        end
    end

endmodule

/* rtl/exec_pipe.sv */
`timescale 1ns/1ps

module exec_pipe (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     squash,
    input  ooo_types_pkg::exec_op_t  op,
    output ooo_types_pkg::complete_t complete
);

    typedef struct packed {
        logic                                valid;
        logic [ooo_cfg_pkg::rob_idx_len-1:0] tag;
        logic [ooo_cfg_pkg::xlen-1:0]        pc;
        logic                                is_branch;
        logic                                pred_taken;
        logic [ooo_cfg_pkg::reg_idx_len-1:0] dest;
        logic [ooo_cfg_pkg::xlen-1:0]        offset;  // sign extended cmp_b
        logic [ooo_cfg_pkg::xlen-1:0]        result;
        logic                                taken;
    } stage2_t;

    ooo_types_pkg::exec_op_t   s1_q;
    stage2_t                   s2_d;
    stage2_t                   s2_q;
    ooo_types_pkg::complete_t  wb_d;
    logic [ooo_cfg_pkg::xlen-1:0] link_pc;
    logic [ooo_cfg_pkg::xlen-1:0] br_target;

    ////////////////////////////////////////
    // stage one, alu and compare
    ////////////////////////////////////////
    always_comb begin
        s2_d            = '0;
        s2_d.valid      = s1_q.valid;
        s2_d.tag        = s1_q.tag;
        s2_d.pc         = s1_q.pc;
        s2_d.is_branch  = s1_q.is_branch;
        s2_d.pred_taken = s1_q.pred_taken;
        s2_d.dest       = s1_q.dest;
        s2_d.offset     = s1_q.op_b;
        unique case (s1_q.alu_op)
            ooo_types_pkg::alu_add: s2_d.result = s1_q.op_a + s1_q.op_b;
            ooo_types_pkg::alu_sub: s2_d.result = s1_q.op_a - s1_q.op_b;
            ooo_types_pkg::alu_and: s2_d.result = s1_q.op_a & s1_q.op_b;
            ooo_types_pkg::alu_xor: s2_d.result = s1_q.op_a ^ s1_q.op_b;
        endcase
        case (s1_q.cond)
            ooo_cfg_pkg::cond_eq: s2_d.taken = (s1_q.op_a == s1_q.op_b);
            ooo_cfg_pkg::cond_lt: s2_d.taken = ($signed(s1_q.op_a) < $signed(s1_q.op_b));
            default:              s2_d.taken = 1'b0;
        endcase
    end

    ////////////////////////////////////////
    // stage two, value and misprediction
    ////////////////////////////////////////
    assign link_pc   = s2_q.pc + ooo_cfg_pkg::pc_step;
    assign br_target = s2_q.taken ? (s2_q.pc + s2_q.offset) : link_pc;

    always_comb begin
        wb_d.valid    = s2_q.valid;
        wb_d.tag      = s2_q.tag;
        wb_d.target   = br_target;
        wb_d.mis_pred = s2_q.is_branch && (s2_q.taken ^ s2_q.pred_taken);
        if (!s2_q.is_branch) begin
            wb_d.value = s2_q.result;
        end else if (s2_q.dest != ooo_cfg_pkg::zero_reg) begin
            wb_d.value = link_pc;  // link goes to the register file
        end else begin
            wb_d.value = br_target;
        end
    end

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            s1_q.valid     <= 1'b0;  // kill everything in flight
            s2_q.valid     <= 1'b0;
            complete.valid <= 1'b0;
        end else begin
            s1_q     <= op;
            s2_q     <= s2_d;
            complete <= wb_d;
        end
    end

endmodule

/* rtl/rob.sv */
`timescale 1ns/1ps

module rob (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                alloc,
    input  logic [ooo_cfg_pkg::xlen-1:0]        alloc_pc,
    input  logic [ooo_cfg_pkg::reg_idx_len-1:0] alloc_dest,
    input  ooo_types_pkg::complete_t            complete,
    output logic [ooo_cfg_pkg::rob_idx_len-1:0] alloc_tag,
    output logic                                full,
    output logic                                squash,
    output logic [ooo_cfg_pkg::xlen-1:0]        redirect_pc,
    output ooo_types_pkg::retire_t              retire
);

    typedef struct packed {
        logic [ooo_cfg_pkg::xlen-1:0]        pc;
        logic                                ready;
        logic [ooo_cfg_pkg::reg_idx_len-1:0] dest;
        logic [ooo_cfg_pkg::xlen-1:0]        value;
        logic [ooo_cfg_pkg::xlen-1:0]        target;  // redirect pc of a branch
        logic                                mis_pred;
    } rob_entry_t;

    rob_entry_t                          entries [ooo_cfg_pkg::rob_size];
    rob_entry_t                          head_entry;
    logic [ooo_cfg_pkg::rob_idx_len-1:0] head;
    logic [ooo_cfg_pkg::rob_idx_len-1:0] tail;
    logic [ooo_cfg_pkg::rob_cnt_len-1:0] count;
    logic                                empty;

    function automatic logic [ooo_cfg_pkg::rob_idx_len-1:0] next_idx(
        input logic [ooo_cfg_pkg::rob_idx_len-1:0] idx
    );
        return (idx == ooo_cfg_pkg::rob_last) ? '0 : idx + 1'b1;
    endfunction

    ////////////////////////////////////////
    // head view and retire
    ////////////////////////////////////////
    assign head_entry = entries[head];
    assign empty      = (count == '0);
    assign full       = (count == ooo_cfg_pkg::rob_full_cnt);
    assign alloc_tag  = tail;

    assign retire.valid  = head_entry.ready && !empty;
    assign retire.pc     = head_entry.pc;
    assign retire.dest   = head_entry.dest;  // zero_reg filtered in the register file
    assign retire.value  = head_entry.value;
    assign squash        = retire.valid && head_entry.mis_pred;
    assign retire.squash = squash;
    assign redirect_pc   = head_entry.target;

    ////////////////////////////////////////
    // pointers and occupancy
    ////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (squash) begin
            head  <= tail;  // drop every younger entry
            count <= '0;
        end else begin
            if (alloc) begin
                tail <= next_idx(tail);
            end
            if (retire.valid) begin
                head <= next_idx(head);
            end
            case ({alloc, retire.valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

    // entry storage
    always_ff @(posedge clock) begin
        if (alloc) begin
            entries[tail] <= '{pc: alloc_pc, dest: alloc_dest, default: '0};
        end
        if (complete.valid && !squash) begin  // completions under squash are younger
            entries[complete.tag].ready    <= 1'b1;
            entries[complete.tag].value    <= complete.value;
            entries[complete.tag].target   <= complete.target;
            entries[complete.tag].mis_pred <= complete.mis_pred;
        end
    end

endmodule

/* rtl/arch_regfile.sv */
`timescale 1ns/1ps

module arch_regfile (
    input  logic                                clock,
    input  logic                                reset,
    input  ooo_types_pkg::retire_t              retire,
    input  logic [ooo_cfg_pkg::reg_idx_len-1:0] read_idx,
    output logic [ooo_cfg_pkg::xlen-1:0]        read_data
);

    logic [ooo_cfg_pkg::xlen-1:0] regs [ooo_cfg_pkg::num_regs];
    logic                         wr_en;

    assign wr_en = retire.valid && (retire.dest != ooo_cfg_pkg::zero_reg);

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < ooo_cfg_pkg::num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[retire.dest] <= retire.value;  // committed state only
        end
    end

    assign read_data = regs[read_idx];  // combinational read

endmodule

/* rtl/ooo_backend.sv */
`timescale 1ns/1ps

module ooo_backend (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                instr_valid,
    input  ooo_types_pkg::instr_word_u          instr,
    input  logic [ooo_cfg_pkg::xlen-1:0]        pc,
    output logic                                instr_ready,
    output ooo_types_pkg::retire_t              retire,
    output logic                                redirect_valid,
    output logic [ooo_cfg_pkg::xlen-1:0]        redirect_pc,
    input  logic [ooo_cfg_pkg::reg_idx_len-1:0] read_idx,
    output logic [ooo_cfg_pkg::xlen-1:0]        read_data
);

    logic                                alloc;
    logic [ooo_cfg_pkg::rob_idx_len-1:0] alloc_tag;
    logic                                full;
    logic                                squash;
    ooo_types_pkg::exec_op_t             op;
    ooo_types_pkg::complete_t            complete;

    assign instr_ready    = !full || retire.valid;  // a retiring head frees a slot
    assign redirect_valid = squash;

    ////////////////////////////////////////
    // pipeline
    ////////////////////////////////////////
    dispatch_stage u_dispatch (
        .clock       (clock),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .instr_ready (instr_ready),
        .alloc_tag   (alloc_tag),
        .squash      (squash),
        .alloc       (alloc),
        .op          (op)
    );

    exec_pipe u_exec (
        .clock    (clock),
        .reset    (reset),
        .squash   (squash),
        .op       (op),
        .complete (complete)
    );

    // dest sits at the same bits in both instruction forms
    rob u_rob (
        .clock       (clock),
        .reset       (reset),
        .alloc       (alloc),
        .alloc_pc    (pc),
        .alloc_dest  (instr.alu.dest),
        .complete    (complete),
        .alloc_tag   (alloc_tag),
        .full        (full),
        .squash      (squash),
        .redirect_pc (redirect_pc),
        .retire      (retire)
    );

    arch_regfile u_regfile (
        .clock     (clock),
        .reset     (reset),
        .retire    (retire),
        .read_idx  (read_idx),
        .read_data (read_data)
    );

endmodule

/* bench/rob_chk.sv */
`timescale 1ns/1ps

module rob_chk (
    input logic                                clock,
    input logic                                reset,
    input logic                                alloc,
    input logic                                full,
    input logic                                squash,
    input logic                                retire_valid,
    input logic [ooo_cfg_pkg::rob_cnt_len-1:0] count
);

    int unsigned fired = 0;  // failed assertions so far

    a_count_max: assert property (@(posedge clock) disable iff (reset)
        count <= ooo_cfg_pkg::rob_full_cnt)
        else begin
            $error("rob occupancy above capacity");
            fired++;
        end

    // a full buffer only takes an entry while its head leaves
    a_full_alloc: assert property (@(posedge clock) disable iff (reset)
        (full && !retire_valid) |-> !alloc)
        else begin
            $error("allocation into a full rob");
            fired++;
        end

    // dispatch holds back the offered word while the head squashes
    a_squash_alloc: assert property (@(posedge clock) disable iff (reset)
        squash |-> !alloc)
        else begin
            $error("allocation during a squash");
            fired++;
        end

    // a squash leaves nothing behind to retire
    a_squash_empty: assert property (@(posedge clock) disable iff (reset)
        squash |=> !retire_valid)
        else begin
            $error("retire right after a squash");
            fired++;
        end

endmodule

bind rob rob_chk u_rob_chk (
    .clock        (clock),
    .reset        (reset),
    .alloc        (alloc),
    .full         (full),
    .squash       (squash),
    .retire_valid (retire.valid),
    .count        (count)
);

/* bench/tb_ooo_backend.sv */
`timescale 1ns/1ps

module tb_ooo_backend;

    typedef struct packed {
        ooo_types_pkg::instr_word_u   word;
        logic [ooo_cfg_pkg::xlen-1:0] pc;
        logic                         timed;  // latency is checked for this one
    } stim_t;

    typedef struct packed {
        logic [ooo_cfg_pkg::xlen-1:0]        pc;
        logic [ooo_cfg_pkg::reg_idx_len-1:0] dest;
        logic [ooo_cfg_pkg::xlen-1:0]        value;
        logic [ooo_cfg_pkg::xlen-1:0]        target;
        logic                                mis;
        logic                                timed;
        logic [31:0]                         acc_cyc;  // edges seen before the accept edge
    } exp_t;

    logic                                clock;
    logic                                reset;
    logic                                instr_valid;
    ooo_types_pkg::instr_word_u          instr;
    logic [ooo_cfg_pkg::xlen-1:0]        pc;
    logic                                instr_ready;
    ooo_types_pkg::retire_t              retire;
    logic                                redirect_valid;
    logic [ooo_cfg_pkg::xlen-1:0]        redirect_pc;
    logic [ooo_cfg_pkg::reg_idx_len-1:0] read_idx;
    logic [ooo_cfg_pkg::xlen-1:0]        read_data;

    stim_t                        stim_q [$];   // offered but not yet accepted
    exp_t                         model_q [$];  // accepted in program order
    logic [ooo_cfg_pkg::xlen-1:0] model_regs [ooo_cfg_pkg::num_regs];
    logic [ooo_cfg_pkg::xlen-1:0] next_pc;
    logic [15:0]                  lfsr = 16'd27978;
    int unsigned                  cyc;
    int                           errors;
    int                           tests_failed;
    int                           retired;
    int                           redirects;
    int                           flushed;
    int                           dropped;
    int                           timed_seen;

    ooo_backend u_dut (
        .clock          (clock),
        .reset          (reset),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .pc             (pc),
        .instr_ready    (instr_ready),
        .retire         (retire),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .read_idx       (read_idx),
        .read_data      (read_data)
    );

    always #5 clock = ~clock;

    always @(posedge clock) cyc <= cyc + 1;

    ////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);  // galois step
            bits = {bits[30:0], lfsr[0]};
        end
        return bits;
    endfunction

    function automatic ooo_types_pkg::instr_word_u alu_word(input logic [1:0] op,
            input logic [4:0] dest, input logic [11:0] a, input logic [11:0] b);
        ooo_types_pkg::instr_word_u w;
        w           = '0;
        w.alu.op    = ooo_types_pkg::alu_op_e'(op);
        w.alu.dest  = dest;
        w.alu.imm_a = a;
        w.alu.imm_b = b;
        return w;
    endfunction

    function automatic ooo_types_pkg::instr_word_u br_word(input logic pred, input logic cond,
            input logic [4:0] dest, input logic [11:0] a, input logic [11:0] b);
        ooo_types_pkg::instr_word_u w;
        w              = '0;
        w.br.is_branch = 1'b1;
        w.br.pred_taken = pred;
        w.br.cond      = cond;
        w.br.dest      = dest;
        w.br.cmp_a     = a;
        w.br.cmp_b     = b;
        return w;
    endfunction

    function automatic logic [31:0] widen(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    // expected outcome of one instruction
    function automatic exp_t ref_model(input ooo_types_pkg::instr_word_u w,
            input logic [31:0] at_pc);
        exp_t        e;
        logic [31:0] a;
        logic [31:0] b;
        logic        taken;
        e    = '0;
        e.pc = at_pc;
        if (!w.alu.is_branch) begin
            a      = widen(w.alu.imm_a);
            b      = widen(w.alu.imm_b);
            e.dest = w.alu.dest;
            case (w.alu.op)
                ooo_types_pkg::alu_add: e.value = a + b;
                ooo_types_pkg::alu_sub: e.value = a - b;
                ooo_types_pkg::alu_and: e.value = a & b;
                default:                e.value = a ^ b;
            endcase
        end else begin
            a        = widen(w.br.cmp_a);
            b        = widen(w.br.cmp_b);
            taken    = w.br.cond ? ($signed(a) < $signed(b)) : (a == b);
            e.dest   = w.br.dest;
            e.target = taken ? at_pc + b : at_pc + 32'd4;
            e.mis    = taken ^ w.br.pred_taken;
            e.value  = (w.br.dest != 5'd0) ? at_pc + 32'd4 : e.target;  // link or target
        end
        return e;
    endfunction

    task automatic add_word(input ooo_types_pkg::instr_word_u w, input logic timed);
        stim_t s;
        s.word  = w;
        s.pc    = next_pc;
        s.timed = timed;
        stim_q.push_back(s);
        next_pc = next_pc + 32'd4;
    endtask

    task automatic add_random_alu();
        logic [31:0] r;
        r = take_bits(31);
        add_word(alu_word(r[30:29], r[28:24], r[23:12], r[11:0]), 1'b0);
    endtask

    task automatic show_mismatch(input string name, input logic [31:0] got,
            input logic [31:0] exp);
        $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
        errors++;
    endtask

    ////////////////////////////////////////
    // driver, drain and register checks
    ////////////////////////////////////////
    task automatic run_stream();
        exp_t e;
        int   waited;
        waited = 0;
        while (stim_q.size() > 0 && waited < 200) begin
            @(negedge clock);
            instr_valid = 1'b1;
            instr       = stim_q[0].word;
            pc          = stim_q[0].pc;
            #1;
            if (redirect_valid) begin
                dropped += stim_q.size();  // wrong path that is never fetched
                stim_q.delete();
            end else if (instr_ready) begin
                e         = ref_model(stim_q[0].word, stim_q[0].pc);
                e.timed   = stim_q[0].timed;
                e.acc_cyc = cyc;
                model_q.push_back(e);
                void'(stim_q.pop_front());
            end else begin
                if (model_q.size() != ooo_cfg_pkg::rob_size) begin
                    $display("t=%0t instr_ready is low while the ROB is not full", $time);
                    errors++;
                end
            end
            waited++;
        end
        if (stim_q.size() > 0) begin
            $display("t=%0t timeout, instructions were never accepted", $time);
            errors++;
            stim_q.delete();
        end
        @(negedge clock);
        instr_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (model_q.size() > 0 && waited < 100) begin
            @(negedge clock);
            #2;
            waited++;
        end
        if (model_q.size() > 0) begin
            $display("t=%0t timeout, %0d instructions never retired", $time, model_q.size());
            errors++;
            model_q.delete();
        end
    endtask

    task automatic check_regs();
        for (int i = 0; i < ooo_cfg_pkg::num_regs; i++) begin
            @(negedge clock);
            read_idx = 5'(i);
            #1;
            if (read_data !== model_regs[i]) begin
                show_mismatch($sformatf("read_data x%0d", i), read_data, model_regs[i]);
            end
        end
    endtask

    task automatic finish_test(input int num, input string name, input int err_before);
        if (errors != err_before) begin
            tests_failed++;
        end
        $display("test %0d %s: %s", num, name, (errors == err_before) ? "ok" : "failed");
    endtask

    ////////////////////////////////////////
    // retire comparison
    ////////////////////////////////////////
    always @(negedge clock) begin : compare_retire
        exp_t e;
        if (!reset && retire.valid) begin
            if (model_q.size() == 0) begin
                $display("t=%0t pc %h retired with nothing outstanding", $time, retire.pc);
                errors++;
            end else begin
                e = model_q.pop_front();
                if (retire.pc !== e.pc) show_mismatch("retire.pc", retire.pc, e.pc);
                if (retire.dest !== e.dest) begin
                    show_mismatch("retire.dest", 32'(retire.dest), 32'(e.dest));
                end
                if (retire.value !== e.value) show_mismatch("retire.value", retire.value, e.value);
                if (retire.squash !== e.mis) begin
                    show_mismatch("retire.squash", 32'(retire.squash), 32'(e.mis));
                end
                if (redirect_valid !== e.mis) begin
                    show_mismatch("redirect_valid", 32'(redirect_valid), 32'(e.mis));
                end
                if (e.mis && redirect_pc !== e.target) begin
                    show_mismatch("redirect_pc", redirect_pc, e.target);
                end
                if (e.mis) begin
                    flushed += model_q.size();  // everything left is younger
                    model_q.delete();
                    redirects++;
                end
                if (e.dest != ooo_cfg_pkg::zero_reg) model_regs[e.dest] = e.value;
                if (e.timed) begin
                    timed_seen++;
                    if (cyc - e.acc_cyc != 32'd5) begin
                        show_mismatch("retire latency", cyc - e.acc_cyc, 32'd5);
                    end
                end
                retired++;
            end
        end else if (!reset && redirect_valid) begin
            $display("t=%0t redirect_valid is high without a retiring branch", $time);
            errors++;
        end
    end

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////
    initial begin
        int eb;
        int base;
        clock = 1'b0;
        reset = 1'b1;
        instr_valid = 1'b0;
        instr = '0;
        pc = '0;
        read_idx = '0;
        next_pc = 32'h0000_1000;
        for (int i = 0; i < ooo_cfg_pkg::num_regs; i++) model_regs[i] = '0;
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        eb = errors;  // state after reset is test 5
        #1;
        if (instr_ready !== 1'b1) show_mismatch("instr_ready", 32'(instr_ready), 32'd1);
        if (retire.valid !== 1'b0) show_mismatch("retire.valid", 32'(retire.valid), 32'd0);
        if (redirect_valid !== 1'b0) show_mismatch("redirect_valid", 32'(redirect_valid), 32'd0);
        check_regs();
        finish_test(5, "reset state", eb);

        eb = errors;
        for (int i = 0; i < 12; i++) add_random_alu();
        run_stream();
        wait_drain();
        check_regs();
        finish_test(1, "alu retire order and values", eb);

        eb = errors;
        base = redirects;
        add_word(br_word(1'b1, 1'b0, 5'd7, 12'h7FF, 12'h7FF), 1'b0);  // eq taken with link
        add_word(br_word(1'b1, 1'b1, 5'd0, 12'hFFD, 12'd8), 1'b0);    // lt taken without link
        add_word(br_word(1'b0, 1'b1, 5'd9, 12'd5, 12'hFFE), 1'b0);    // lt not taken with link
        run_stream();
        wait_drain();
        check_regs();
        if (redirects != base) begin
            $display("a correctly predicted branch raised a redirect");
            errors++;
        end
        finish_test(2, "predicted branches", eb);

        eb = errors;
        base = redirects;
        add_word(alu_word(2'd0, 5'd10, 12'd40, 12'd2), 1'b0);
        add_word(alu_word(2'd1, 5'd11, 12'd40, 12'd2), 1'b0);
        add_word(br_word(1'b1, 1'b0, 5'd0, 12'd3, 12'd9), 1'b0);  // predicted taken but falls through
        for (int i = 0; i < 8; i++) begin
            add_word(alu_word(2'd3, 5'(20 + i), 12'h0F0, 12'(i + 1)), 1'b0);
        end
        run_stream();
        wait_drain();
        check_regs();
        if (redirects != base + 1) begin
            $display("expected one redirect, saw %0d", redirects - base);
            errors++;
        end
        finish_test(3, "mispredicted branch squash", eb);

        eb = errors;
        base = retired;
        for (int i = 0; i < 20; i++) add_random_alu();
        run_stream();
        wait_drain();
        check_regs();
        if (retired != base + 20) show_mismatch("retired count", 32'(retired - base), 32'd20);
        finish_test(4, "burst of 20", eb);

        eb = errors;
        base = timed_seen;
        add_word(alu_word(2'd0, 5'd3, 12'd100, 12'd23), 1'b1);
        run_stream();
        wait_drain();
        if (timed_seen != base + 1) begin
            $display("the isolated instruction never retired");
            errors++;
        end
        finish_test(6, "isolated latency", eb);

        if (u_dut.u_rob.u_rob_chk.fired != 0) begin
            $display("%0d ROB assertions failed", u_dut.u_rob.u_rob_chk.fired);
            errors++;
        end
        $display("summary: 6 tests, %0d failed, %0d errors, %0d retired, %0d flushed, %0d dropped",
                 tests_failed, errors, retired, flushed, dropped);
        if (errors == 0 && tests_failed == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
rtl/ooo_cfg_pkg.sv
rtl/ooo_types_pkg.sv
rtl/dispatch_stage.sv
rtl/exec_pipe.sv
rtl/rob.sv
rtl/arch_regfile.sv
rtl/ooo_backend.sv
bench/rob_chk.sv
bench/tb_ooo_backend.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_ooo_backend
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS ?= --lint-only --timing -Wall
PASS_TEXT ?= ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
